// File: verilog.f
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu.sv
testbench/cpu_asserts.sv
testbench/cpu_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpu_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: program.hex
// one 32-bit instruction word per line, loaded from byte address 0x00 upward
// columns: hex word, then its byte address and the instruction it encodes
05a00093 // 00 addi x1, x0, 0x5a
03308113 // 04 addi x2, x1, 0x33
002081b3 // 08 add  x3, x1, x2
40308233 // 0c sub  x4, x1, x3
003272b3 // 10 and  x5, x4, x3
0012e333 // 14 or   x6, x5, x1
004343b3 // 18 xor  x7, x6, x4
00539433 // 1c sll  x8, x7, x5
005454b3 // 20 srl  x9, x8, x5
7f04f513 // 24 andi x10, x9, 0x7f0
08a56593 // 28 ori  x11, x10, 0x08a
fff5c613 // 2c xori x12, x11, -1
00461693 // 30 slli x13, x12, 4
0086d713 // 34 srli x14, x13, 8
00e02823 // 38 sw   x14, 16(x0)
01002783 // 3c lw   x15, 16(x0)
00178833 // 40 add  x16, x15, x1
00e78663 // 44 beq  x15, x14, +12
00100913 // 48 addi x18, x0, 1
00100993 // 4c addi x19, x0, 1
00f81663 // 50 bne  x16, x15, +12
00100a13 // 54 addi x20, x0, 1
00100a93 // 58 addi x21, x0, 1
00208463 // 5c beq  x1, x2, +8
05500b13 // 60 addi x22, x0, 0x55
12300013 // 64 addi x0, x0, 0x123
00300893 // 68 addi x17, x0, 3
00000073 // 6c ecall
00a00893 // 70 addi x17, x0, 10
00000073 // 74 ecall
00000013 // 78 nop
00000013 // 7c nop
00000063 // 80 beq  x0, x0, 0

// File: testbench/cpu_tb.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_tb import rv_isa_pkg::*, pipe_pkg::*; ();

  localparam int CLK_PERIOD  = 10; // ns
  localparam int PROG_WORDS  = 33; // words in program.hex
  localparam int WATCHDOG_NS = (PROG_WORDS * 4 + 20) * CLK_PERIOD; // room for stalls, flushes
  localparam int NUM_EXPECT  = 18;

  typedef struct packed {
    reg_idx_t idx;
    word_t    value;
  } reg_expect_t;

  // architectural result of program.hex run in program order, worked by hand
  localparam reg_expect_t EXPECT_TABLE [NUM_EXPECT] = '{
    '{5'd1,  32'h0000_005a}, // 90
    '{5'd2,  32'h0000_008d}, // 0x5a + 0x33
    '{5'd3,  32'h0000_00e7}, // x1 + x2
    '{5'd4,  32'hffff_ff73}, // x1 - x3 wraps negative
    '{5'd5,  32'h0000_0063}, // x4 & x3
    '{5'd6,  32'h0000_007b}, // x5 | x1
    '{5'd7,  32'hffff_ff08}, // x6 ^ x4
    '{5'd8,  32'hffff_f840}, // x7 << 3, shamt from low bits of x5
    '{5'd9,  32'h1fff_ff08}, // logical >> 3, zero fill
    '{5'd10, 32'h0000_0700}, // & 0x7f0
    '{5'd11, 32'h0000_078a}, // | 0x08a
    '{5'd12, 32'hffff_f875}, // ^ -1, sign-extended imm
    '{5'd13, 32'hffff_8750}, // << 4
    '{5'd14, 32'h00ff_ff87}, // >> 8
    '{5'd15, 32'h00ff_ff87}, // loaded back from word 4
    '{5'd16, 32'h00ff_ffe1}, // load value + x1
    '{5'd17, 32'h0000_000a}, // exit code, last write before halt
    '{5'd22, 32'h0000_0055}  // after the not-taken beq
  };

  logic      clk;
  logic      reset;
  logic      is_halted;
  reg_dump_t print_reg;

  cpu cpu_inst (
    .clk, .reset, .is_halted, .print_reg
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("timeout: processor never halted");
  end

  initial begin
    wait (cpu_inst.cpu_asserts_inst.error_seen === 1'b1); // bound checker tripped
    abort_run("a pipeline assertion failed");
  end

  initial begin
    word_t expected [NUM_REGS];
    reset = 1'b1;
    repeat (2) @(negedge clk); // two reset edges
    reset = 1'b0;
    @(negedge clk);
    check_flag("is_halted", is_halted, 1'b0);
    while (is_halted !== 1'b1) begin // first ecall must not get here
      @(negedge clk);
    end
    for (int r = 0; r < NUM_REGS; r++) begin
      expected[r] = '0; // untouched, skipped and x0 stay zero
    end
    for (int n = 0; n < NUM_EXPECT; n++) begin
      expected[EXPECT_TABLE[n].idx] = EXPECT_TABLE[n].value;
    end
    for (int r = 0; r < NUM_REGS; r++) begin
      check_word($sformatf("print_reg[%0d]", r), print_reg[r], expected[r]);
    end
    @(negedge clk);
    check_flag("is_halted", is_halted, 1'b0); // one-cycle pulse, nops follow
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/cpu_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_asserts import pipe_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      stall,
  input redirect_t redirect,
  input logic      is_halted,
  input id_ex_t    id_ex,
  input word_t     op_a,
  input word_t     pc
);

  logic error_seen = 1'b0; // set by any failing property

  // MEM/WB cleared by reset, nothing can be halting yet
  halt_low_after_reset: assert property (@(posedge clk) reset |=> !is_halted)
    else begin
      error_seen = 1'b1;
      $error("is_halted high in the cycle after reset");
    end

  // a write to x0 in MEM or WB must not reach operand a
  x0_operand_zero: assert property (@(posedge clk) disable iff (reset)
      id_ex.rs1 == '0 |-> op_a == '0)
    else begin
      error_seen = 1'b1;
      $error("operand a not zero for source register x0");
    end

  // load-use or ecall wait, redirect absent
  pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
      stall && !redirect.taken |=> pc == $past(pc))
    else begin
      error_seen = 1'b1;
      $error("pc moved during a stall cycle");
    end

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
  .clk, .reset, .stall, .redirect, .is_halted, .id_ex,
  .op_a(execute_inst.op_a), // forwarded rs1 value
  .pc(fetch_inst.pc)        // pc lives inside fetch
);

`default_nettype wire

// File: rtl/cpu.sv
`default_nettype none
`timescale 1ns/100ps

module cpu import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output logic      is_halted,
  output reg_dump_t print_reg
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  redirect_t redirect;
  reg_idx_t  id_rs1;
  reg_idx_t  id_rs2;
  logic      id_uses_rs2;
  logic      id_is_ecall;
  logic      stall;
  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;
  fwd_sel_t  fwd_store;

  fetch_stage fetch_inst (
    .clk, .reset, .stall, .redirect, .if_id
  );

  decode_stage decode_inst (
    .clk, .reset, .if_id, .stall, .redirect, .mem_wb, // mem_wb is the write port
    .id_rs1, .id_rs2, .id_uses_rs2, .id_is_ecall, .id_ex, .print_reg
  );

  hazard_unit hazard_inst (
    .id_rs1, .id_rs2, .id_uses_rs2, .id_is_ecall, .id_ex, .ex_mem, .mem_wb,
    .stall, .fwd_a, .fwd_b, .fwd_store
  );

  execute_stage execute_inst (
    .clk, .reset, .id_ex, .ex_mem, .mem_wb, .fwd_a, .fwd_b, .fwd_store,
    .redirect, .ex_mem_q(ex_mem)
  );

  memory_stage memory_inst (
    .clk, .reset, .ex_mem, .mem_wb
  );

  assign is_halted = mem_wb.is_halted; // halting ecall reached WB

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`default_nettype none
`timescale 1ns/100ps

module memory_stage import pipe_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output mem_wb_t mem_wb
);

  word_t                         dmem [DMEM_WORDS] = '{default: '0};
  logic [$clog2(DMEM_WORDS)-1:0] addr;
  word_t                         load_data;

  assign addr      = ex_mem.alu_out[$clog2(DMEM_WORDS)+1:2]; // word index
  assign load_data = ex_mem.mem_read ? dmem[addr] : '0;      // async read

  always_ff @(posedge clk) begin
    if (ex_mem.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.is_halted <= ex_mem.is_halted;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.wb_data   <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_out; // wb mux
    end
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  id_ex_t    id_ex,
  input  ex_mem_t   ex_mem,
  input  mem_wb_t   mem_wb,
  input  fwd_sel_t  fwd_a,
  input  fwd_sel_t  fwd_b,
  input  fwd_sel_t  fwd_store,
  output redirect_t redirect,
  output ex_mem_t   ex_mem_q
);

  word_t   op_a;
  word_t   rs2_fwd;
  word_t   op_b;
  word_t   store_data;
  word_t   alu_out;
  alu_op_t alu_op;
  logic    cond;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
    case (sel)
      FWD_MEM: return ex_mem.alu_out;
      FWD_WB:  return mem_wb.wb_data;
      default: return reg_val;
    endcase
  endfunction

  assign op_a       = fwd_mux(fwd_a, id_ex.rs1_data);
  assign rs2_fwd    = fwd_mux(fwd_b, id_ex.rs2_data);
  assign op_b       = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;
  assign store_data = fwd_mux(fwd_store, id_ex.rs2_data);

  always_comb begin
    alu_op = ADD;
    case (id_ex.ctrl.alu_class)
      MEM_ADDR:   alu_op = ADD;
      BRANCH_CMP: alu_op = SUB;
      default: begin // reg and imm ops share the funct3 map
        case (id_ex.funct3)
          F3_ADD_SUB: alu_op = (id_ex.ctrl.alu_class == REG_OP && id_ex.funct7_30) ? SUB : ADD;
          F3_SLL:     alu_op = SLL;
          F3_XOR:     alu_op = XOR;
          F3_SRL:     alu_op = SRL;
          F3_OR:      alu_op = OR;
          F3_AND:     alu_op = AND;
          default:    alu_op = ADD;
        endcase
      end
    endcase
  end

  always_comb begin
    case (alu_op)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      AND:     alu_out = op_a & op_b;
      OR:      alu_out = op_a | op_b;
      XOR:     alu_out = op_a ^ op_b;
      SLL:     alu_out = op_a << op_b[4:0]; // shamt is low 5 bits
      SRL:     alu_out = op_a >> op_b[4:0];
      default: alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (id_ex.funct3)
      F3_BEQ:  cond = (op_a == rs2_fwd);
      F3_BNE:  cond = (op_a != rs2_fwd);
      default: cond = 1'b0;
    endcase
  end

  assign redirect.taken  = id_ex.ctrl.is_branch && cond; // predicted not taken
  assign redirect.target = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem_q.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem_q.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem_q.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem_q.is_halted  <= id_ex.ctrl.is_halted;
      ex_mem_q.alu_out    <= alu_out;
      ex_mem_q.store_data <= store_data;
      ex_mem_q.rd         <= id_ex.rd;
    end
  end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit import rv_isa_pkg::*, pipe_pkg::*; (
  input  reg_idx_t id_rs1,
  input  reg_idx_t id_rs2,
  input  logic     id_uses_rs2,
  input  logic     id_is_ecall,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  output logic     stall,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output fwd_sel_t fwd_store
);

  logic load_use;
  logic ecall_wait;

  // youngest producer first
  function automatic fwd_sel_t pick(input reg_idx_t src);
    if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == src) begin
      return FWD_MEM;
    end
    if (mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0
                    && (id_ex.rd == id_rs1 || (id_uses_rs2 && id_ex.rd == id_rs2));

  // x17 still in EX or MEM; WB is covered by the regfile bypass
  assign ecall_wait = id_is_ecall
                      && ((id_ex.ctrl.reg_write && id_ex.rd == HALT_ARG_REG)
                          || (ex_mem.reg_write && ex_mem.rd == HALT_ARG_REG));

  assign stall = load_use || ecall_wait;

  always_comb begin
    fwd_a     = pick(id_ex.rs1);
    fwd_b     = id_ex.ctrl.alu_src ? FWD_NONE : pick(id_ex.rs2);   // reg operand only
    fwd_store = id_ex.ctrl.mem_write ? pick(id_ex.rs2) : FWD_NONE; // sw data
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  if_id_t    if_id,
  input  logic      stall,
  input  redirect_t redirect,
  input  mem_wb_t   mem_wb,
  output reg_idx_t  id_rs1,
  output reg_idx_t  id_rs2,
  output logic      id_uses_rs2,
  output logic      id_is_ecall,
  output id_ex_t    id_ex,
  output reg_dump_t print_reg
);

  word_t   rf [1:NUM_REGS-1]; // x0 has no storage
  inst_t   inst;
  opcode_t opcode;
  ctrl_t   ctrl;
  word_t   imm;
  word_t   rs1_data;
  word_t   rs2_data;

  function automatic word_t rf_read(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (mem_wb.reg_write && mem_wb.rd == idx) begin
      return mem_wb.wb_data; // same-cycle WB bypass
    end
    return rf[idx];
  endfunction

  assign inst        = if_id.inst;
  assign opcode      = inst.r_fmt.opcode; // rs1/rs2/rd/opcode sit alike in all formats
  assign id_is_ecall = (opcode == SYSTEM) && (inst.i_fmt.funct3 == 3'b000)
                       && (inst.i_fmt.imm12 == '0);
  assign id_rs1      = id_is_ecall ? HALT_ARG_REG : inst.r_fmt.rs1; // ecall reads a7
  assign id_rs2      = inst.r_fmt.rs2;
  assign id_uses_rs2 = opcode inside {OP, STORE, BRANCH};
  assign rs1_data    = rf_read(id_rs1);
  assign rs2_data    = rf_read(id_rs2);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (mem_wb.reg_write && mem_wb.rd != '0) begin
      rf[mem_wb.rd] <= mem_wb.wb_data;
    end
  end

  always_comb begin
    print_reg[0] = '0; // x0 hardwired
    for (int i = 1; i < NUM_REGS; i++) begin
      print_reg[i] = rf[i];
    end
  end

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP: begin
        ctrl.alu_class = REG_OP;
        ctrl.reg_write = 1'b1;
      end
      OP_IMM: begin
        ctrl.alu_class = IMM_OP;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      LOAD: begin
        ctrl.alu_class  = MEM_ADDR; // base + offset
        ctrl.alu_src    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
      end
      STORE: begin
        ctrl.alu_class = MEM_ADDR;
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      BRANCH: begin
        ctrl.alu_class = BRANCH_CMP;
        ctrl.is_branch = 1'b1;
      end
      SYSTEM: ctrl.is_halted = id_is_ecall && (rs1_data == HALT_CODE);
      default: ctrl = '0; // unknown or zero word is a nop
    endcase
  end

  always_comb begin
    case (opcode)
      OP_IMM, LOAD: imm = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
      STORE:        imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
      BRANCH: begin
        imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
               inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0}; // halfword offset
      end
      default:      imm = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || stall || redirect.taken) begin
      id_ex <= '0; // bubble
    end else begin
      id_ex.ctrl      <= ctrl;
      id_ex.pc        <= if_id.pc;
      id_ex.rs1_data  <= rs1_data;
      id_ex.rs2_data  <= rs2_data;
      id_ex.imm       <= imm;
      id_ex.rs1       <= id_rs1;
      id_ex.rs2       <= id_rs2;
      id_ex.rd        <= inst.r_fmt.rd;
      id_ex.funct3    <= inst.r_fmt.funct3;
      id_ex.funct7_30 <= inst.r_fmt.funct7[5];
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_stage import pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  redirect_t redirect,
  output if_id_t    if_id
);

  word_t pc;
  word_t next_pc;
  word_t fetch_word;
  word_t imem [IMEM_WORDS];

  initial begin
    $readmemh(IMEM_FILE, imem); // program image
  end

  assign fetch_word = imem[pc[$clog2(IMEM_WORDS)+1:2]]; // async read, word index

  always_comb begin
    if (redirect.taken) begin
      next_pc = redirect.target; // branch resolved in EX wins
    end else if (stall) begin
      next_pc = pc;              // hold for load-use / ecall
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect.taken) begin
      if_id <= '0;              // zero word decodes as nop
    end else if (!stall) begin
      if_id.pc   <= pc;
      if_id.inst <= fetch_word;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  localparam int NUM_REGS = 32;
  typedef logic [NUM_REGS-1:0][XLEN-1:0] reg_dump_t; // word i is x<i>

  localparam int    IMEM_WORDS = 256;  // word addressed by addr[9:2]
  localparam int    DMEM_WORDS = 256;
  localparam string IMEM_FILE  = "program.hex";

  typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLL, SRL} alu_op_t;

  // coarse class from decode, refined in EX by funct3/funct7
  typedef enum logic [1:0] {MEM_ADDR, BRANCH_CMP, REG_OP, IMM_OP} alu_class_t;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

  typedef struct packed {
    alu_class_t alu_class;
    logic       alu_src;    // 1 = immediate as operand b
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       reg_write;
    logic       is_branch;
    logic       is_halted;  // ecall with x17 == 10
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t      ctrl;
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    logic       funct7_30;  // sub vs add
  } id_ex_t;

  typedef struct packed {
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     is_halted;
    word_t    alu_out;
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_write;
    logic     is_halted;
    reg_idx_t rd;
    word_t    wb_data;
  } mem_wb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011, // lw
    OP_IMM = 7'b0010011, // addi andi ori xori slli srli
    STORE  = 7'b0100011, // sw
    OP     = 7'b0110011, // reg-reg alu
    BRANCH = 7'b1100011, // beq bne
    SYSTEM = 7'b1110011  // ecall
  } opcode_t;

  typedef logic [4:0] reg_idx_t; // x0..x31

  // one instruction word, viewed through its encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      opcode_t    opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;  // sign bit at [11]
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      opcode_t     opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;  // imm[11:5]
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;  // imm[4:0]
      opcode_t    opcode;
    } s_fmt;
    struct packed {
      logic       imm12;   // sign
      logic [5:0] imm10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_t    opcode;
    } b_fmt;
  } inst_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000; // add sub addi
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam reg_idx_t    HALT_ARG_REG = 5'd17;  // a7 holds the ecall code
  localparam logic [31:0] HALT_CODE    = 32'd10; // exit

endpackage

`default_nettype wire
